/* common/a2_host_pkg.sv */
// Shared localparams and packed structs for the Apple II+ host glue

package a2_host_pkg;

	// ====================
	// Image slots
	// ====================

	localparam int unsigned SLOT_FLOPPY1 = 0;
	localparam int unsigned SLOT_HDD     = 1;
	localparam int unsigned SLOT_FLOPPY2 = 2;
	localparam int unsigned NUM_SLOTS    = 3;

	// ====================
	// Memory geometry
	// ====================

	// 192K main bank plus 64K auxiliary bank
	localparam int unsigned RAM_ADDR_W     = 18;
	localparam int unsigned MAIN_RAM_WORDS = 196608;
	localparam int unsigned AUX_RAM_WORDS  = 65536;
	localparam int unsigned AUX_ADDR_W     = 16;

	// Pixel enable divider
	localparam int unsigned PIX_DIV_W = 3;

	// ====================
	// Structs
	// ====================

	// Option word from the host menu
	typedef struct packed {
		logic       analog_swap;
		logic [2:0] scandoubler_fx;
		logic       pixel_normal;
		logic       paddle_x;
		logic       paddle_y;
		logic [1:0] screen_mode;
		logic       lores_composite;
		logic [1:0] palette;
		logic [3:0] spare;
	} a2_status_t;

	// Write-back of stepped display options
	typedef struct packed {
		logic       set;
		logic [1:0] screen_mode;
		logic [1:0] palette;
	} a2_status_req_t;

	// SD block request for one slot
	typedef struct packed {
		logic rd;
		logic wr;
	} sd_req_t;

	// Mount report, mounted is a single-cycle pulse
	typedef struct packed {
		logic        mounted;
		logic        readonly;
		logic [63:0] size;
	} img_info_t;

	// Machine side memory access
	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            din;
		logic                  we;
		logic                  aux;
	} ram_req_t;

endpackage

/* hdd/hdd_request.sv */
// Hard-disk SD request sequencer with CPU wait and acknowledge edge detection

`timescale 1ns/1ps

module hdd_request (
	input  logic                 clk_sys,
	input  logic                 dd_reset,
	input  logic                 hdd_read,
	input  logic                 hdd_write,
	input  logic                 sd_ack,
	output a2_host_pkg::sd_req_t hdd_sd,
	output logic                 cpu_wait
);

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} state_t;

	state_t state;
	logic   ack_d;
	logic   ack_rise;
	logic   ack_fall;
	logic   rd_pending;
	logic   wr_pending;

	// Edges of the host acknowledge
	assign ack_rise = sd_ack & ~ack_d;
	assign ack_fall = ~sd_ack & ack_d;

	// ====================
	// Sequencer
	// ====================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state      <= ST_IDLE;
			ack_d      <= 1'b0;
			rd_pending <= 1'b0;
			wr_pending <= 1'b0;
			hdd_sd     <= '0;
			cpu_wait   <= 1'b0;
		end else begin
			ack_d      <= sd_ack;
			// Pulses from the machine collect here until served
			rd_pending <= rd_pending | hdd_read;
			wr_pending <= wr_pending | hdd_write;

			case (state)
				ST_IDLE: begin
					if (rd_pending | wr_pending) begin
						state     <= ST_BUSY;
						hdd_sd.rd <= rd_pending;
						hdd_sd.wr <= wr_pending;
						cpu_wait  <= 1'b1;
					end
				end
				ST_BUSY: begin
					if (ack_rise) begin
						// Host took the block so only a pulse in this same cycle stays pending
						rd_pending <= hdd_read;
						wr_pending <= hdd_write;
						hdd_sd     <= '0;
					end else if (ack_fall) begin
						// Transfer done so the CPU runs again
						state    <= ST_IDLE;
						cpu_wait <= 1'b0;
					end
				end
			endcase
		end
	end

	// The CPU must be held for as long as a request is outstanding
	a_req_holds_cpu: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(hdd_sd.rd | hdd_sd.wr) |-> cpu_wait)
		else $error("SD request raised while the CPU is not held");

endmodule

/* hdl/image_mount.sv */
// Mount, write-protect and disk-change tracking for two floppies and one hard disk

`timescale 1ns/1ps

module image_mount (
	input  logic                   clk_sys,
	input  logic                   dd_reset,
	input  a2_host_pkg::img_info_t img [a2_host_pkg::NUM_SLOTS],
	output logic                   hdd_mounted,
	output logic                   hdd_protect,
	output logic [1:0]             disk_mount,
	output logic [1:0]             disk_change
);

	logic [a2_host_pkg::NUM_SLOTS-1:0] mounted_vec;

	for (genvar s = 0; s < a2_host_pkg::NUM_SLOTS; s++) begin : g_pulse
		assign mounted_vec[s] = img[s].mounted;
	end

	// Hard disk keeps its protect bit, an empty image counts as unmounted
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			hdd_mounted <= 1'b0;
			hdd_protect <= 1'b0;
		end else if (img[a2_host_pkg::SLOT_HDD].mounted) begin
			hdd_mounted <= |img[a2_host_pkg::SLOT_HDD].size;
			hdd_protect <= img[a2_host_pkg::SLOT_HDD].readonly;
		end
	end

	// Floppies toggle a change bit so the track buffer can reload
	for (genvar f = 0; f < 2; f++) begin : g_floppy
		localparam int unsigned SLOT = (f == 0) ? a2_host_pkg::SLOT_FLOPPY1
		                                        : a2_host_pkg::SLOT_FLOPPY2;
		logic mount_q;
		logic change_q;

		always_ff @(posedge clk_sys) begin
			if (dd_reset) begin
				mount_q  <= 1'b0;
				change_q <= 1'b0;
			end else if (img[SLOT].mounted) begin
				mount_q  <= |img[SLOT].size;
				change_q <= ~change_q;
			end
		end

		assign disk_mount[f]  = mount_q;
		assign disk_change[f] = change_q;
	end

	// Host reports one image at a time
	a_one_mount: assert property (@(posedge clk_sys) disable iff (dd_reset)
		$onehot0(mounted_vec))
		else $error("More than one mount pulse in a cycle");

endmodule

/* hdl/option_decode.sv */
// Joystick remapping, display and palette stepping, scanline, text artifact and pixel enable

`timescale 1ns/1ps

module option_decode (
	input  logic                        clk_sys,
	input  logic                        dd_reset,
	input  a2_host_pkg::a2_status_t     status,
	input  logic                        video_step,
	input  logic                        palette_step,
	input  logic [5:0]                  joystick_0,
	input  logic [15:0]                 joystick_a0,
	input  logic [7:0]                  paddle_0,
	output a2_host_pkg::a2_status_req_t status_req,
	output logic [5:0]                  joy_dig,
	output logic [15:0]                 joy_an,
	output logic [1:0]                  vga_sl,
	output logic                        text_color,
	output logic                        ce_pix
);

	logic [7:0]                        pdl;
	logic [15:0]                       joys;
	logic [2:0]                        sl_full;
	logic                              req_set;
	logic [1:0]                        req_mode;
	logic [1:0]                        req_pal;
	logic [a2_host_pkg::PIX_DIV_W-1:0] div;

	// ====================
	// Joystick
	// ====================

	// Paddle is offset binary, flip the top bit to centre it
	assign pdl = {~paddle_0[7], paddle_0[6:0]};

	// Host delivers Y in the low byte, swap unless asked not to
	assign joys = status.analog_swap ? joystick_a0 : {joystick_a0[7:0], joystick_a0[15:8]};

	assign joy_an = {status.paddle_x ? pdl : joys[15:8],
	                 status.paddle_y ? pdl : joys[7:0]};

	// Buttons always pass, a direction pair drops while its analog axis is deflected
	assign joy_dig = joystick_0 & {2'b11, {2{~|joys[7:0]}}, {2{~|joys[15:8]}}};

	// ====================
	// Step requests
	// ====================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			req_set <= 1'b0;
		end else begin
			req_set <= video_step | palette_step;
		end
	end

	// Palette change forces colour mode and wins over a display step
	always_ff @(posedge clk_sys) begin
		if (palette_step) begin
			req_pal  <= status.palette + 2'd1;
			req_mode <= 2'd0;
		end else if (video_step) begin
			req_pal  <= status.palette;
			req_mode <= status.screen_mode + 2'd1;
		end
	end

	assign status_req = '{set: req_set, screen_mode: req_mode, palette: req_pal};

	// ====================
	// Video options
	// ====================

	// Scandoubler setting 0 is none, 1 is HQ2x, then the scanline depths
	assign sl_full = (status.scandoubler_fx != 3'd0) ? status.scandoubler_fx - 3'd1 : 3'd0;

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			vga_sl     <= 2'd0;
			text_color <= 1'b0;
		end else begin
			vga_sl     <= sl_full[1:0];
			// Lo-Res text artifacts only make sense in colour mode
			text_color <= (status.screen_mode == 2'd0) & status.lores_composite;
		end
	end

	// Pixel enable every 8 clocks in normal mode, every 4 when doubled
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			div    <= '0;
			ce_pix <= 1'b0;
		end else begin
			div    <= div + 1'b1;
			ce_pix <= status.pixel_normal ? &div : &div[1:0];
		end
	end

endmodule

/* memory/ram_banks.sv */
// Main and auxiliary RAM banks read together as one 16-bit word

`timescale 1ns/1ps

module ram_banks (
	input  logic                  clk_sys,
	input  a2_host_pkg::ram_req_t ram_req,
	output logic [15:0]           ram_dout
);

	logic [7:0]                         main_mem [a2_host_pkg::MAIN_RAM_WORDS];
	logic [7:0]                         aux_mem  [a2_host_pkg::AUX_RAM_WORDS];
	logic [a2_host_pkg::AUX_ADDR_W-1:0] aux_addr;
	logic                               main_we;
	logic                               aux_we;
	logic [7:0]                         main_q;
	logic [7:0]                         aux_q;

	assign aux_addr = ram_req.addr[a2_host_pkg::AUX_ADDR_W-1:0];
	assign main_we  = ram_req.we & ~ram_req.aux;
	assign aux_we   = ram_req.we & ram_req.aux;

	// Main bank, written byte shows up on the output in the same access
	always_ff @(posedge clk_sys) begin
		if (main_we) begin
			main_mem[ram_req.addr] <= ram_req.din;
			main_q                 <= ram_req.din;
		end else begin
			main_q <= main_mem[ram_req.addr];
		end
	end

	// Auxiliary bank uses the low 16 address bits
	always_ff @(posedge clk_sys) begin
		if (aux_we) begin
			aux_mem[aux_addr] <= ram_req.din;
			aux_q             <= ram_req.din;
		end else begin
			aux_q <= aux_mem[aux_addr];
		end
	end

	assign ram_dout = {aux_q, main_q};

	// Machine never maps a main write past 192K
	a_main_range: assert property (@(posedge clk_sys)
		main_we |-> (ram_req.addr < a2_host_pkg::MAIN_RAM_WORDS))
		else $error("Main bank write out of range");

endmodule

/* hdl/a2_host_top.sv */
// Top level connecting the HDD sequencer, mount tracking, option decode and RAM banks

`timescale 1ns/1ps

module a2_host_top (
	input  logic                        clk_sys,
	input  logic                        dd_reset,

	// Host side
	input  a2_host_pkg::a2_status_t     status,
	input  a2_host_pkg::img_info_t      img [a2_host_pkg::NUM_SLOTS],
	input  logic                        sd_ack,
	input  logic                        video_step,
	input  logic                        palette_step,
	input  logic [5:0]                  joystick_0,
	input  logic [15:0]                 joystick_a0,
	input  logic [7:0]                  paddle_0,

	// Machine side
	input  logic                        hdd_read,
	input  logic                        hdd_write,
	input  a2_host_pkg::ram_req_t       ram_req,

	output a2_host_pkg::sd_req_t        hdd_sd,
	output logic                        cpu_wait,
	output logic                        hdd_mounted,
	output logic                        hdd_protect,
	output logic [1:0]                  disk_mount,
	output logic [1:0]                  disk_change,
	output a2_host_pkg::a2_status_req_t status_req,
	output logic [5:0]                  joy_dig,
	output logic [15:0]                 joy_an,
	output logic [1:0]                  vga_sl,
	output logic                        text_color,
	output logic                        ce_pix,
	output logic [15:0]                 ram_dout
);

	// ====================
	// Hard disk requests
	// ====================

	hdd_request hdd_request_i (
		.clk_sys   (clk_sys),
		.dd_reset  (dd_reset),
		.hdd_read  (hdd_read),
		.hdd_write (hdd_write),
		.sd_ack    (sd_ack),
		.hdd_sd    (hdd_sd),
		.cpu_wait  (cpu_wait)
	);

	// Mount state for both floppies and the hard disk
	image_mount image_mount_i (
		.clk_sys     (clk_sys),
		.dd_reset    (dd_reset),
		.img         (img),
		.hdd_mounted (hdd_mounted),
		.hdd_protect (hdd_protect),
		.disk_mount  (disk_mount),
		.disk_change (disk_change)
	);

	// ====================
	// Options and video
	// ====================

	option_decode option_decode_i (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.status       (status),
		.video_step   (video_step),
		.palette_step (palette_step),
		.joystick_0   (joystick_0),
		.joystick_a0  (joystick_a0),
		.paddle_0     (paddle_0),
		.status_req   (status_req),
		.joy_dig      (joy_dig),
		.joy_an       (joy_an),
		.vga_sl       (vga_sl),
		.text_color   (text_color),
		.ce_pix       (ce_pix)
	);

	// Main and auxiliary memory
	ram_banks ram_banks_i (
		.clk_sys  (clk_sys),
		.ram_req  (ram_req),
		.ram_dout (ram_dout)
	);

endmodule

/* verification/tb_a2_model.svh */
// Reference models for stepping, joystick, scanline and mount tracking, plus RAM bank shadows
`ifndef TB_A2_MODEL_SVH
`define TB_A2_MODEL_SVH

logic [7:0] main_shadow [int];
logic [7:0] aux_shadow [int];
logic       m_hdd_mounted;
logic       m_hdd_protect;
logic [1:0] m_disk_mount;
logic [1:0] m_disk_change;

// X and Y bytes after the swap, either one may be replaced by the centred paddle
function automatic logic [15:0] joy_an_model(a2_host_pkg::a2_status_t st, logic [15:0] a0,
		logic [7:0] pdl);
	logic [7:0] x_byte;
	logic [7:0] y_byte;
	x_byte = st.analog_swap ? a0[15:8] : a0[7:0];
	y_byte = st.analog_swap ? a0[7:0] : a0[15:8];
	if (st.paddle_x) x_byte = pdl ^ 8'h80;
	if (st.paddle_y) y_byte = pdl ^ 8'h80;
	return {x_byte, y_byte};
endfunction

function automatic logic [5:0] joy_dig_model(a2_host_pkg::a2_status_t st, logic [5:0] dig,
		logic [15:0] a0);
	logic [15:0] sw;
	logic [5:0]  res;
	sw  = st.analog_swap ? a0 : {a0[7:0], a0[15:8]};
	res = dig;
	if (sw[7:0] != 8'd0) res[3:2] = 2'b00;
	if (sw[15:8] != 8'd0) res[1:0] = 2'b00;
	return res;
endfunction

// Palette step wins and forces screen mode 0
function automatic a2_host_pkg::a2_status_req_t step_model(a2_host_pkg::a2_status_t st,
		logic vstep, logic pstep);
	a2_host_pkg::a2_status_req_t req;
	req.set         = vstep | pstep;
	req.screen_mode = pstep ? 2'd0 : st.screen_mode + {1'b0, vstep};
	req.palette     = st.palette + {1'b0, pstep};
	return req;
endfunction

task automatic mount_model(int unsigned slot, logic ro, logic [63:0] size);
	int idx;
	idx = (slot == a2_host_pkg::SLOT_FLOPPY1) ? 0 : 1;
	if (slot == a2_host_pkg::SLOT_HDD) begin
		m_hdd_mounted = (size != 64'd0);
		m_hdd_protect = ro;
	end else begin
		m_disk_mount[idx]  = (size != 64'd0);
		m_disk_change[idx] = ~m_disk_change[idx];
	end
endtask

// Expected word for one access, known marks which halves have been written before
task automatic ram_model(a2_host_pkg::ram_req_t req, output logic [15:0] word,
		output logic [1:0] known);
	int main_key;
	int aux_key;
	main_key = int'(req.addr);
	aux_key  = int'(req.addr[15:0]);
	if (req.we && !req.aux) main_shadow[main_key] = req.din;
	if (req.we && req.aux) aux_shadow[aux_key] = req.din;
	known[0]   = main_shadow.exists(main_key);
	known[1]   = aux_shadow.exists(aux_key);
	word[7:0]  = known[0] ? main_shadow[main_key] : 8'h00;
	word[15:8] = known[1] ? aux_shadow[aux_key] : 8'h00;
endtask

`endif

/* verification/tb_a2_host.sv */
// Testbench top with clock, reset, random stimulus, model checks and watchdog
`timescale 1ns/1ps

module tb_a2_host;

	localparam int HDD_RUNS    = 20;
	localparam int MOUNT_RUNS  = 100;
	localparam int MEM_RUNS    = 300;
	localparam int STEP_RUNS   = 100;
	localparam int OPT_RUNS    = 100;
	// One HDD run with a queued pulse takes about 45 cycles in the worst case
	localparam int TEST_CYCLES = 8 + HDD_RUNS * 48 + MOUNT_RUNS + MEM_RUNS + STEP_RUNS
	                             + OPT_RUNS * 2 + 2 * 80;
	localparam int WATCHDOG_NS = TEST_CYCLES * 4 * 2;

	logic                        clk_sys = 1'b0;
	logic                        dd_reset;
	a2_host_pkg::a2_status_t     status;
	a2_host_pkg::img_info_t      img [a2_host_pkg::NUM_SLOTS];
	logic                        sd_ack;
	logic                        hdd_read;
	logic                        hdd_write;
	logic                        video_step;
	logic                        palette_step;
	logic [5:0]                  joystick_0;
	logic [15:0]                 joystick_a0;
	logic [7:0]                  paddle_0;
	a2_host_pkg::ram_req_t       ram_req;
	a2_host_pkg::sd_req_t        hdd_sd;
	logic                        cpu_wait;
	logic                        hdd_mounted;
	logic                        hdd_protect;
	logic [1:0]                  disk_mount;
	logic [1:0]                  disk_change;
	a2_host_pkg::a2_status_req_t status_req;
	logic [5:0]                  joy_dig;
	logic [15:0]                 joy_an;
	logic [1:0]                  vga_sl;
	logic                        text_color;
	logic                        ce_pix;
	logic [15:0]                 ram_dout;
	integer                      seed = 32'hb971;
	int                          errors = 0;
	int                          checks = 0;
	int                          errors_before = 0;

	`include "tb_a2_model.svh"

	always #2 clk_sys = ~clk_sys;

	a2_host_top a2_host_top_i (.*);

	// ====================
	// Helpers
	// ====================

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(logic cond, string what);
		checks++;
		assert (cond) else begin
			$display("Error at %0d ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_test(string name);
		$display("Test %s done with %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	task automatic hdd_pulse(logic is_wr);
		hdd_read  = ~is_wr;
		hdd_write = is_wr;
		next_cycle();
		hdd_read  = 1'b0;
		hdd_write = 1'b0;
	endtask

	// Host acknowledge cycle that can queue another pulse while it runs
	task automatic ack_service(logic chain, logic next_wr);
		int i;
		repeat ($random(seed) & 7) next_cycle();
		sd_ack = 1'b1;
		next_cycle();
		check_value("hdd_sd", hdd_sd, 2'b00);
		check_value("cpu_wait", cpu_wait, 1'b1);
		if (chain) hdd_pulse(next_wr);
		repeat ($random(seed) & 7) next_cycle();
		sd_ack = 1'b0;
		for (i = 0; i < 2 && cpu_wait; i++) next_cycle();
		check_true(!cpu_wait, "cpu_wait still high two cycles after sd_ack fell");
	endtask

	// ====================
	// Tests
	// ====================

	task automatic hdd_sequence_test();
		logic [31:0] r;
		repeat (HDD_RUNS) begin
			r = $random(seed);
			hdd_pulse(r[0]);
			next_cycle();
			check_value("hdd_sd", hdd_sd, {~r[0], r[0]});
			check_value("cpu_wait", cpu_wait, 1'b1);
			ack_service(r[1], r[2]);
			if (r[1]) begin
				next_cycle();
				check_value("hdd_sd", hdd_sd, {~r[2], r[2]});
				check_value("cpu_wait", cpu_wait, 1'b1);
				ack_service(1'b0, 1'b0);
			end
			next_cycle();
		end
	endtask

	task automatic mount_test();
		logic [31:0] r;
		int unsigned slot;
		logic [63:0] size;
		repeat (MOUNT_RUNS) begin
			r    = $random(seed);
			slot = r[1:0] % 3;
			size = r[2] ? {$random(seed), $random(seed)} : 64'd0;
			img[slot] = '{mounted: 1'b1, readonly: r[3], size: size};
			mount_model(slot, r[3], size);
			next_cycle();
			img[slot].mounted = 1'b0;
			check_value("hdd_mounted", hdd_mounted, m_hdd_mounted);
			check_value("hdd_protect", hdd_protect, m_hdd_protect);
			check_value("disk_mount", disk_mount, m_disk_mount);
			check_value("disk_change", disk_change, m_disk_change);
		end
	endtask

	task automatic memory_test();
		logic [31:0] r;
		logic [15:0] exp_word;
		logic [1:0]  known;
		repeat (MEM_RUNS) begin
			r = $random(seed);
			ram_req.addr = {(r[9:8] == 2'd3) ? 2'd0 : r[9:8], 10'd0, r[5:0]};
			ram_req.din  = r[17:10];
			ram_req.we   = r[18];
			ram_req.aux  = r[19];
			ram_model(ram_req, exp_word, known);
			next_cycle();
			if (known[0]) check_value("ram_dout[7:0]", ram_dout[7:0], exp_word[7:0]);
			if (known[1]) check_value("ram_dout[15:8]", ram_dout[15:8], exp_word[15:8]);
		end
		ram_req.we = 1'b0;
	endtask

	task automatic step_test();
		logic [31:0]                 r;
		a2_host_pkg::a2_status_req_t exp_req;
		repeat (STEP_RUNS) begin
			r            = $random(seed);
			status       = r[15:0];
			video_step   = r[16];
			palette_step = r[17];
			exp_req      = step_model(status, r[16], r[17]);
			next_cycle();
			video_step   = 1'b0;
			palette_step = 1'b0;
			check_value("status_req.set", status_req.set, exp_req.set);
			if (exp_req.set) begin
				check_value("status_req.screen_mode", status_req.screen_mode, exp_req.screen_mode);
				check_value("status_req.palette", status_req.palette, exp_req.palette);
			end
		end
	endtask

	task automatic option_test();
		logic [31:0] r;
		logic [31:0] r2;
		repeat (OPT_RUNS) begin
			r           = $random(seed);
			r2          = $random(seed);
			status      = r[15:0];
			joystick_0  = r[21:16];
			joystick_a0 = {r[22] ? 8'd0 : r2[15:8], r[23] ? 8'd0 : r2[7:0]};
			paddle_0    = r2[23:16];
			#1;
			check_value("joy_an", joy_an, joy_an_model(status, joystick_a0, paddle_0));
			check_value("joy_dig", joy_dig, joy_dig_model(status, joystick_0, joystick_a0));
			next_cycle();
			check_value("vga_sl", vga_sl,
			            (status.scandoubler_fx == 3'd0) ? 2'd0 : 2'(status.scandoubler_fx - 3'd1));
			check_value("text_color", text_color,
			            (status.screen_mode == 2'd0) && status.lores_composite);
		end
	endtask

	task automatic pixel_enable_test();
		int count;
		for (int i = 0; i < 2; i++) begin
			status.pixel_normal = i[0];
			repeat (8) next_cycle();
			count = 0;
			repeat (64) begin
				next_cycle();
				count += int'(ce_pix);
			end
			check_value("ce_pix count", count, i[0] ? 8 : 16);
		end
	endtask

	initial begin
		dd_reset     = 1'b1;
		status       = '0;
		img          = '{default: '0};
		sd_ack       = 1'b0;
		hdd_read     = 1'b0;
		hdd_write    = 1'b0;
		video_step   = 1'b0;
		palette_step = 1'b0;
		joystick_0   = '0;
		joystick_a0  = '0;
		paddle_0     = '0;
		ram_req      = '0;
		m_hdd_mounted = 1'b0;
		m_hdd_protect = 1'b0;
		m_disk_mount  = 2'b00;
		m_disk_change = 2'b00;
		repeat (8) @(posedge clk_sys);
		#1 dd_reset = 1'b0;
		check_value("cpu_wait", cpu_wait, 1'b0);
		check_value("hdd_sd", hdd_sd, 2'b00);
		check_value("status_req.set", status_req.set, 1'b0);
		check_value("ce_pix", ce_pix, 1'b0);
		check_value("mount flags", {hdd_mounted, disk_mount, disk_change}, 5'd0);
		report_test("reset");
		hdd_sequence_test();
		report_test("hdd sequence");
		mount_test();
		report_test("mount tracking");
		memory_test();
		report_test("memory");
		step_test();
		report_test("stepping");
		option_test();
		report_test("option decoding");
		pixel_enable_test();
		report_test("pixel enable");
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog sized from the test lengths
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("Finished with errors");
		$finish;
	end

endmodule

/* list.f */
+incdir+verification
common/a2_host_pkg.sv
hdd/hdd_request.sv
hdl/image_mount.sv
hdl/option_decode.sv
memory/ram_banks.sv
hdl/a2_host_top.sv
verification/tb_a2_host.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass is decided from the log
set -u
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_a2_host \
	-f list.f -Mdir obj_dir -o tb_a2_host
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_a2_host > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Finished with no errors" "$log"; then
	exit 0
fi
exit 1
